//--- dv/drumTb.sv
`timescale 1ns/1ps

module drumTb;

  // Small mesh keeps the reference model quick
  localparam int xSize = 4;
  localparam int ySize = 4;

  // 18-bit limits with 16 fraction bits
  localparam longint satHi = 131071;
  localparam longint satLo = -131072;
  localparam longint initInner = -32768;

  // Run length, used to size the watchdog
  localparam int idleCycles = 10;
  localparam int plannedSamples = 200 + 7 * 60 + 60 + 60 + 30 + 60;
  localparam int plannedStrikes = 12;
  localparam int watchdogCycles = 2 * (plannedSamples + 10 * plannedStrikes + idleCycles + 4);

  logic allValid;
  logic rstN;
  logic strike;
  meshPkg::coefT rho;
  meshPkg::coefT eta;
  meshPkg::shiftT tensionSel;
  meshPkg::sampleT sampleOut;
  logic sampleValid;
  meshPkg::sampleT peakOut;

  // Reference mesh state and timbre of the current strike
  longint mU [ySize][xSize];
  longint mUp [ySize][xSize];
  longint mRho;
  longint mEta;
  int mTsel;
  longint mPeak;
  bit sawSat;

  int runSamples;
  int sampleErrors;
  int peakErrors;
  int validErrors;
  int otherErrors;

  drumTop #(
    .xSize (xSize),
    .ySize (ySize)
  ) u_dut (
    .allValid    (allValid),
    .rstN        (rstN),
    .strike      (strike),
    .rho         (rho),
    .eta         (eta),
    .tensionSel  (tensionSel),
    .sampleOut   (sampleOut),
    .sampleValid (sampleValid),
    .peakOut     (peakOut)
  );

  initial begin
    allValid = 1'b0;
    forever #5 allValid = ~allValid;
  end

  // Fresh mesh shape, flat on row 0 and column 0
  function automatic void resetModel(input meshPkg::coefT rhoV, input meshPkg::coefT etaV,
                                     input meshPkg::shiftT tselV);
    for (int y = 0; y < ySize; y++) begin
      for (int x = 0; x < xSize; x++) begin
        mU[y][x]  = (x == 0 || y == 0) ? 0 : initInner;
        mUp[y][x] = mU[y][x];
      end
    end
    mRho = rhoV;
    mEta = etaV;
    mTsel = tselV;
    mPeak = 0;
    sawSat = 1'b0;
    runSamples = 0;
  endfunction

  // One leapfrog step of the whole mesh, returns the far corner
  function automatic meshPkg::sampleT nextCorner();
    longint nU [ySize][xSize];
    longint c, n, s, e, w, lap, tens, damp, nxt, mag;
    for (int y = 0; y < ySize; y++) begin
      for (int x = 0; x < xSize; x++) begin
        c = mU[y][x];
        // North and west see zero, south and east reflect the node
        n = 0;
        w = 0;
        s = c;
        e = c;
        if (y > 0) n = mU[y-1][x];
        if (x > 0) w = mU[y][x-1];
        if (y < ySize - 1) s = mU[y+1][x];
        if (x < xSize - 1) e = mU[y][x+1];
        lap  = n + s + e + w - 4 * c;
        tens = ((mRho * lap) >>> 16) >>> mTsel;
        damp = (mEta * (c - mUp[y][x])) >>> 16;
        nxt  = 2 * c - mUp[y][x] + tens - damp;
        if (nxt > satHi) nxt = satHi;
        if (nxt < satLo) nxt = satLo;
        nU[y][x] = nxt;
      end
    end
    mUp = mU;
    mU = nU;
    c = mU[ySize-1][xSize-1];
    if (c == satHi || c == satLo) sawSat = 1'b1;
    // Magnitude of the most negative value clips to the top
    mag = (c < 0) ? -c : c;
    if (mag > satHi) mag = satHi;
    if (mag > mPeak) mPeak = mag;
    return meshPkg::sampleT'(c);
  endfunction

  task automatic checkSample(input meshPkg::sampleT expVal);
    if (sampleOut !== expVal) begin
      sampleErrors++;
      $display("[FAIL] t=%0t sampleOut expected %0d got %0d", $time, expVal, sampleOut);
    end
  endtask

  task automatic checkPeak(input meshPkg::sampleT expVal);
    if (peakOut !== expVal) begin
      peakErrors++;
      $display("[FAIL] t=%0t peakOut expected %0d got %0d", $time, expVal, peakOut);
    end
  endtask

  task automatic checkValid(input logic expVal);
    if (sampleValid !== expVal) begin
      validErrors++;
      $display("[FAIL] t=%0t sampleValid expected %0b got %0b", $time, expVal, sampleValid);
    end
  endtask

  // rho in 0.05 .. 0.25
  function automatic meshPkg::coefT randomRho();
    return meshPkg::coefT'(3277 + ($urandom % 13108));
  endfunction

  // eta in 0 .. 0.1
  function automatic meshPkg::coefT randomEta();
    return meshPkg::coefT'($urandom % 6555);
  endfunction

  // Strike, follow the load sequence, then wait for nSamples samples
  task automatic runStrike(input meshPkg::coefT rhoV, input meshPkg::coefT etaV,
                           input meshPkg::shiftT tselV, input int nSamples);
    int waitCycles;
    @(posedge allValid);
    #1;
    strike = 1'b1;
    rho = rhoV;
    eta = etaV;
    tensionSel = tselV;
    // Strike sampled here, samples of the old run may still come
    @(posedge allValid);
    #1;
    strike = 1'b0;
    // Load cycle starts, the old run is over
    @(posedge allValid);
    #1;
    resetModel(rhoV, etaV, tselV);
    @(negedge allValid);
    checkValid(1'b0);
    // Meter cleared by the load
    @(negedge allValid);
    checkValid(1'b0);
    checkPeak('0);
    waitCycles = 2;
    while (!sampleValid && waitCycles < 4) begin
      @(negedge allValid);
      waitCycles++;
    end
    if (!sampleValid) begin
      otherErrors++;
      $display("No sample arrived within 4 cycles of the strike at t=%0t", $time);
    end else if (waitCycles != 4) begin
      otherErrors++;
      $display("First sample came %0d cycles after the strike instead of 4", waitCycles);
    end else begin
      while (runSamples < nSamples) @(posedge allValid);
    end
  endtask

  // Compare every valid sample against the model
  initial begin : compare
    meshPkg::sampleT expCorner;
    forever begin
      @(negedge allValid);
      if (rstN && sampleValid) begin
        expCorner = nextCorner();
        checkSample(expCorner);
        checkPeak(meshPkg::sampleT'(mPeak));
        runSamples++;
      end
    end
  end

  initial begin : watchdog
    #(watchdogCycles * 10);
    $display("Timeout, the run did not finish within %0d cycles", watchdogCycles);
    $display("test failed");
    $finish;
  end

  initial begin : stimulus
    int totalErrors;
    rstN = 1'b0;
    strike = 1'b0;
    rho = '0;
    eta = '0;
    tensionSel = '0;
    runSamples = 0;
    sampleErrors = 0;
    peakErrors = 0;
    validErrors = 0;
    otherErrors = 0;
    void'($urandom(21));
    repeat (4) @(posedge allValid);
    #1;
    rstN = 1'b1;
    // Quiet outputs before any strike
    repeat (idleCycles) begin
      @(negedge allValid);
      checkValid(1'b0);
      checkSample('0);
      checkPeak('0);
    end
    // Long run, full tension
    runStrike(randomRho(), randomEta(), 3'd0, 200);
    // Every softer tension setting
    for (int t = 1; t < 8; t++) begin
      runStrike(randomRho(), randomEta(), meshPkg::shiftT'(t), 60);
    end
    // No damping, then an unstable setting that clips
    runStrike(randomRho(), '0, 3'd0, 60);
    runStrike(18'sd98304, 18'sd122880, 3'd0, 60);
    if (!sawSat) begin
      otherErrors++;
      $display("The clipping run never reached the sample limits at the corner");
    end
    // Restrike in the middle of a run
    runStrike(randomRho(), randomEta(), 3'd0, 30);
    runStrike(randomRho(), randomEta(), 3'd2, 60);
    totalErrors = sampleErrors + peakErrors + validErrors + otherErrors;
    $display("Errors: sample %0d, peak %0d, valid %0d, other %0d",
             sampleErrors, peakErrors, validErrors, otherErrors);
    if (totalErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- flist.f
logic/meshPkg.sv
logic/ctrlPkg.sv
logic/meshCtrlIf.sv
logic/exciteControl.sv
logic/meshNode.sv
logic/membraneMesh.sv
logic/pickupTap.sv
logic/drumTop.sv
dv/drumTb.sv

//--- logic/ctrlPkg.sv
package ctrlPkg;

  // Excitation FSM states
  // idle until the first strike
  // load for one cycle while nodes take their initial shape
  // run while the mesh steps every cycle
  typedef enum logic [1:0] {
    idle,
    load,
    run
  } exciteStateT;

endpackage

//--- logic/drumTop.sv
`timescale 1ns/1ps

module drumTop #(
  parameter int xSize = 16,
  parameter int ySize = 16
) (
  input  logic            allValid,
  input  logic            rstN,
  input  logic            strike,
  input  meshPkg::coefT   rho,
  input  meshPkg::coefT   eta,
  input  meshPkg::shiftT  tensionSel,
  output meshPkg::sampleT sampleOut,
  output logic            sampleValid,
  output meshPkg::sampleT peakOut
);

  // Mesh-to-pickup link
  meshPkg::sampleT cornerU;
  logic stepped;

  // Control bus from excitation to mesh
  meshCtrlIf ctlBus ();

  // Input side
  exciteControl uExcite (
    .allValid  (allValid),
    .rstN      (rstN),
    .strike    (strike),
    .rhoIn     (rho),
    .etaIn     (eta),
    .tensionIn (tensionSel),
    .ctl       (ctlBus.ctrl)
  );

  // Node grid
  membraneMesh #(
    .xSize (xSize),
    .ySize (ySize)
  ) uMesh (
    .allValid (allValid),
    .rstN     (rstN),
    .ctl      (ctlBus.mesh),
    .cornerU  (cornerU),
    .stepped  (stepped)
  );

  // Output side, also watches load to clear the meter
  pickupTap uPickup (
    .allValid    (allValid),
    .rstN        (rstN),
    .load        (ctlBus.load),
    .stepped     (stepped),
    .cornerU     (cornerU),
    .sampleOut   (sampleOut),
    .sampleValid (sampleValid),
    .peakOut     (peakOut)
  );

endmodule

//--- logic/exciteControl.sv
`timescale 1ns/1ps

module exciteControl (
  input  logic           allValid,
  input  logic           rstN,
  input  logic           strike,
  input  meshPkg::coefT  rhoIn,
  input  meshPkg::coefT  etaIn,
  input  meshPkg::shiftT tensionIn,
  meshCtrlIf.ctrl        ctl
);

  ctrlPkg::exciteStateT state;
  logic strikeQ;
  logic strikeHit;
  logic strikeRise;
  logic loadNow;
  logic stepNow;
  meshPkg::coefT rhoQ;
  meshPkg::coefT etaQ;
  meshPkg::shiftT tensionQ;

  // A held strike counts once
  assign strikeRise = strike & ~strikeQ;

  // Strike edge detect and timbre capture
  always_ff @(posedge allValid or negedge rstN) begin
    if (!rstN) begin
      strikeQ   <= 1'b0;
      strikeHit <= 1'b0;
      rhoQ      <= '0;
      etaQ      <= '0;
      tensionQ  <= '0;
    end else begin
      strikeQ   <= strike;
      strikeHit <= strikeRise;
      // Controls are taken in the strike cycle
      if (strikeRise) begin
        rhoQ     <= rhoIn;
        etaQ     <= etaIn;
        tensionQ <= tensionIn;
      end
    end
  end

  // Load/run FSM
  // A strike restarts it from any state
  always_ff @(posedge allValid or negedge rstN) begin
    if (!rstN) begin
      state <= ctrlPkg::idle;
    end else if (strikeHit) begin
      state <= ctrlPkg::load;
    end else begin
      case (state)
        ctrlPkg::load: state <= ctrlPkg::run;
        ctrlPkg::run:  state <= ctrlPkg::run;
        default:       state <= ctrlPkg::idle;
      endcase
    end
  end

  assign loadNow = (state == ctrlPkg::load);
  assign stepNow = (state == ctrlPkg::run);

  // Drive the mesh control bus
  assign ctl.load       = loadNow;
  assign ctl.step       = stepNow;
  assign ctl.rho        = rhoQ;
  assign ctl.eta        = etaQ;
  assign ctl.tensionSel = tensionQ;

  // A strike edge gives load two edges later and run right after it
  strikeLoadRun: assert property (@(posedge allValid) disable iff (!rstN)
    strikeRise |-> ##2 loadNow ##1 stepNow)
    else $error("strike did not lead to load and then run");

  // Even back-to-back strikes give single-cycle load pulses
  loadSingleCycle: assert property (@(posedge allValid) disable iff (!rstN)
    loadNow |=> !loadNow)
    else $error("load held longer than one cycle");

endmodule

//--- logic/membraneMesh.sv
`timescale 1ns/1ps

module membraneMesh #(
  parameter int xSize = 16,
  parameter int ySize = 16
) (
  input  logic            allValid,
  input  logic            rstN,
  meshCtrlIf.mesh         ctl,
  output meshPkg::sampleT cornerU,
  output logic            stepped
);

  // Initial interior displacement, minus one half
  localparam meshPkg::sampleT initInterior =
    meshPkg::sampleT'(-(1 <<< (meshPkg::fracBits - 1)));

  // Node displacements, row y and column x
  meshPkg::sampleT meshU [ySize][xSize];

  for (genvar y = 0; y < ySize; y++) begin : gRow
    for (genvar x = 0; x < xSize; x++) begin : gCol
      // Row 0 and column 0 start flat
      localparam meshPkg::sampleT uInit = (x == 0 || y == 0) ? '0 : initInterior;

      meshPkg::sampleT uNorth;
      meshPkg::sampleT uSouth;
      meshPkg::sampleT uEast;
      meshPkg::sampleT uWest;

      // North and west edges are clamped to zero
      if (y == 0) begin : gNorthEdge
        assign uNorth = '0;
      end else begin : gNorthIn
        assign uNorth = meshU[y-1][x];
      end
      if (x == 0) begin : gWestEdge
        assign uWest = '0;
      end else begin : gWestIn
        assign uWest = meshU[y][x-1];
      end

      // South and east edges reflect the node itself
      if (y == ySize - 1) begin : gSouthEdge
        assign uSouth = meshU[y][x];
      end else begin : gSouthIn
        assign uSouth = meshU[y+1][x];
      end
      if (x == xSize - 1) begin : gEastEdge
        assign uEast = meshU[y][x];
      end else begin : gEastIn
        assign uEast = meshU[y][x+1];
      end

      meshNode node (
        .allValid   (allValid),
        .rstN       (rstN),
        .load       (ctl.load),
        .step       (ctl.step),
        .uInit      (uInit),
        .uNorth     (uNorth),
        .uSouth     (uSouth),
        .uEast      (uEast),
        .uWest      (uWest),
        .rho        (ctl.rho),
        .eta        (ctl.eta),
        .tensionSel (ctl.tensionSel),
        .u          (meshU[y][x])
      );
    end
  end

  // Far corner is the pickup point
  assign cornerU = meshU[ySize-1][xSize-1];
  // Pickup needs to know which cycles update the mesh
  assign stepped = ctl.step;

endmodule

//--- logic/meshCtrlIf.sv
`timescale 1ns/1ps

interface meshCtrlIf;

  // One-cycle pulse, nodes take their initial value
  logic load;
  // High while the mesh runs, one update per cycle
  logic step;

  // Timbre controls, constant between strikes
  meshPkg::coefT rho;
  meshPkg::coefT eta;
  meshPkg::shiftT tensionSel;

  // Excitation side drives everything
  modport ctrl (output load, output step, output rho, output eta, output tensionSel);

  // Mesh side only listens
  modport mesh (input load, input step, input rho, input eta, input tensionSel);

endinterface

//--- logic/meshNode.sv
`timescale 1ns/1ps

module meshNode (
  input  logic            allValid,
  input  logic            rstN,
  input  logic            load,
  input  logic            step,
  input  meshPkg::sampleT uInit,
  input  meshPkg::sampleT uNorth,
  input  meshPkg::sampleT uSouth,
  input  meshPkg::sampleT uEast,
  input  meshPkg::sampleT uWest,
  input  meshPkg::coefT   rho,
  input  meshPkg::coefT   eta,
  input  meshPkg::shiftT  tensionSel,
  output meshPkg::sampleT u
);

  // Widths sized so no intermediate can overflow
  localparam int lapW      = meshPkg::sampleW + 3;
  localparam int tensProdW = meshPkg::sampleW + lapW;
  localparam int diffW     = meshPkg::sampleW + 1;
  localparam int dampProdW = meshPkg::sampleW + diffW;
  localparam int sumW      = meshPkg::sampleW + 6;

  meshPkg::sampleT uPrev;
  meshPkg::sampleT uNext;
  logic signed [lapW-1:0] lap;
  logic signed [tensProdW-1:0] tensProd;
  logic signed [tensProdW-1:0] tensShifted;
  logic signed [diffW-1:0] velocity;
  logic signed [dampProdW-1:0] dampProd;
  logic signed [dampProdW-1:0] dampShifted;
  logic signed [sumW-1:0] nextWide;

  always_comb begin
    // Discrete Laplacian of the four neighbours
    lap = lapW'(uNorth) + lapW'(uSouth) + lapW'(uEast) + lapW'(uWest) - (lapW'(u) <<< 2);
    // Tension term is rescaled then softened by tensionSel
    tensProd    = tensProdW'(rho) * tensProdW'(lap);
    tensShifted = (tensProd >>> meshPkg::fracBits) >>> tensionSel;
    // Damping on the per-step velocity
    velocity    = diffW'(u) - diffW'(uPrev);
    dampProd    = dampProdW'(eta) * dampProdW'(velocity);
    dampShifted = dampProd >>> meshPkg::fracBits;
    // Leapfrog update 2u - uPrev + tension - damping
    nextWide = (sumW'(u) <<< 1) - sumW'(uPrev) + sumW'(tensShifted) - sumW'(dampShifted);
    // Clamp to the sample range
    if (nextWide > sumW'(meshPkg::satMax)) begin
      uNext = meshPkg::satMax;
    end else if (nextWide < sumW'(meshPkg::satMin)) begin
      uNext = meshPkg::satMin;
    end else begin
      uNext = meshPkg::sampleT'(nextWide);
    end
  end

  // Both time levels of the node start from uInit
  always_ff @(posedge allValid or negedge rstN) begin
    if (!rstN) begin
      u     <= '0;
      uPrev <= '0;
    end else if (load) begin
      u     <= uInit;
      uPrev <= uInit;
    end else if (step) begin
      uPrev <= u;
      u     <= uNext;
    end
  end

  // Load has priority here and would swallow a step in the same cycle
  loadStepApart: assert property (@(posedge allValid) disable iff (!rstN)
    !(load && step))
    else $error("node saw load and step together");

endmodule

//--- logic/meshPkg.sv
package meshPkg;

  // Word width of displacements, samples and coefficients
  localparam int sampleW = 18;

  // Fraction bits of the fixed-point format
  localparam int fracBits = 16;

  // Width of the tension shift select
  localparam int shiftW = 3;

  // Node displacement or audio sample
  typedef logic signed [sampleW-1:0] sampleT;

  // Timbre coefficient, rho or eta
  typedef logic signed [sampleW-1:0] coefT;

  // Extra right shift on the tension term
  typedef logic [shiftW-1:0] shiftT;

  // Saturation limits of a sample
  localparam sampleT satMax = sampleT'((1 <<< (sampleW - 1)) - 1);
  localparam sampleT satMin = sampleT'(-(1 <<< (sampleW - 1)));

endpackage

//--- logic/pickupTap.sv
`timescale 1ns/1ps

module pickupTap (
  input  logic            allValid,
  input  logic            rstN,
  input  logic            load,
  input  logic            stepped,
  input  meshPkg::sampleT cornerU,
  output meshPkg::sampleT sampleOut,
  output logic            sampleValid,
  output meshPkg::sampleT peakOut
);

  logic steppedQ;
  logic validQ;
  meshPkg::sampleT mag;

  // Magnitude of the corner, the most negative value saturates
  always_comb begin
    if (cornerU == meshPkg::satMin) begin
      mag = meshPkg::satMax;
    end else if (cornerU < 0) begin
      mag = -cornerU;
    end else begin
      mag = cornerU;
    end
  end

  // steppedQ marks the cycle right after an update edge
  always_ff @(posedge allValid or negedge rstN) begin
    if (!rstN) begin
      steppedQ  <= 1'b0;
      validQ    <= 1'b0;
      sampleOut <= '0;
      peakOut   <= '0;
    end else if (load) begin
      // New strike, drop samples in flight and clear the meter
      steppedQ <= 1'b0;
      validQ   <= 1'b0;
      peakOut  <= '0;
    end else begin
      steppedQ <= stepped;
      validQ   <= steppedQ;
      if (steppedQ) begin
        sampleOut <= cornerU;
        if (mag > peakOut) begin
          peakOut <= mag;
        end
      end
    end
  end

  // Strobe is suppressed in the load cycle of a restrike
  assign sampleValid = validQ & ~load;

  // Each sample traces back to an update two cycles earlier
  validFollowsStep: assert property (@(posedge allValid) disable iff (!rstN)
    sampleValid |-> $past(stepped, 2))
    else $error("sampleValid without a preceding step");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the drum membrane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module drumTb -o drumSim

./obj_dir/drumSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
